// ==== project.f ====
+incdir+include
rtl/alu_pkg.sv
rtl/alu.sv
rtl/cmd_fifo.sv
rtl/axil_cmd_port.sv
rtl/alu_exec.sv
rtl/alu_accel_top.sv
testbench/tb_alu_accel.sv

// ==== include/axil_host_tasks.svh ====
`ifndef AXIL_HOST_TASKS_SVH
`define AXIL_HOST_TASKS_SVH

// Host side drives on the falling edge and samples there too
task automatic axil_write(input logic [4:0] addr, input logic [31:0] data,
                          output logic [1:0] resp);
  @(negedge clk);
  awaddr  = addr;
  wdata   = data;
  awvalid = 1'b1;
  wvalid  = 1'b1;
  bready  = 1'b1;
  while (!(awready && wready))
    @(negedge clk);
  @(negedge clk);
  awvalid = 1'b0;
  wvalid  = 1'b0;
  while (!bvalid)
    @(negedge clk);
  resp = bresp;
endtask

task automatic axil_read(input logic [4:0] addr, output logic [31:0] data,
                         output logic [1:0] resp);
  @(negedge clk);
  araddr  = addr;
  arvalid = 1'b1;
  rready  = 1'b1;
  while (!arready)
    @(negedge clk);
  @(negedge clk);
  arvalid = 1'b0;
  while (!rvalid)
    @(negedge clk);
  data = rdata;
  resp = rresp;
endtask

// Returns {flags, result} in the REG_RESULT layout
function automatic logic [23:0] alu_model(input logic [4:0] op, input logic [15:0] x,
                                          input logic [15:0] y, input logic cin);
  logic [16:0] s;
  logic [15:0] r;
  logic        ci;
  logic        c;
  logic        v;
  logic        z;
  logic        sg;
  logic        n;
  r  = '0;
  c  = 1'b0;
  v  = 1'b0;
  ci = (op == OP_ADC || op == OP_SBC) ? cin : 1'b0;
  case (op)
    OP_ADD8, OP_ADC: begin
      s = x[7:0] + y[7:0] + ci;
      r = {8'h00, s[7:0]};
      c = s[8];
      v = (x[7] == y[7]) && (r[7] != x[7]);
    end
    OP_SUB8, OP_SBC: begin
      s = x[7:0] - y[7:0] - ci;
      r = {8'h00, s[7:0]};
      c = s[8];
      v = (x[7] != y[7]) && (r[7] != x[7]);
    end
    OP_ADD16, OP_SUB16: begin
      s = (op == OP_ADD16) ? x + y : x - y;
      r = s[15:0];
      c = s[16];
      v = (op == OP_ADD16) ? (x[15] == y[15]) : (x[15] != y[15]);
      v = v && (r[15] != x[15]);
    end
    OP_AND: r[7:0] = x[7:0] & y[7:0];
    OP_OR:  r[7:0] = x[7:0] | y[7:0];
    OP_XOR: r[7:0] = x[7:0] ^ y[7:0];
    OP_NOT: r[7:0] = ~x[7:0];
    OP_RR, OP_RRC, OP_SRA, OP_SRL: begin
      c = x[0];
      r[6:0] = x[7:1];
      r[7] = (op == OP_RR) ? cin : (op == OP_RRC) ? x[0] : (op == OP_SRA) ? x[7] : 1'b0;
    end
    OP_RL, OP_RLC, OP_SLA, OP_SLL: begin
      c = x[7];
      r[7:1] = x[6:0];
      r[0] = (op == OP_RL) ? cin : (op == OP_RLC) ? x[7] : (op == OP_SLL) ? 1'b1 : 1'b0;
    end
    OP_RES: r[7:0] = x[7:0] & ~(8'h01 << y[2:0]);
    OP_SET: r[7:0] = x[7:0] | (8'h01 << y[2:0]);
    default: ;
  endcase
  if (op == OP_AND || op == OP_OR || op == OP_XOR || op == OP_SLA || op == OP_SRA ||
      op == OP_SLL)
    v = ~^r[7:0];
  z  = (op == OP_BIT) ? ~x[y[3:0]] : (r == 16'h0000);
  sg = (op == OP_ADD16 || op == OP_SUB16) ? r[15] : r[7];
  n  = (op == OP_ADD8 || op == OP_ADC || op == OP_ADD16);
  if (op > OP_BIT)
    return 24'h000000;
  return {sg, z, 3'b000, v, n, c, r};
endfunction

`endif

// ==== testbench/tb_alu_accel.sv ====
`timescale 1ns/1ns

module tb_alu_accel
  import alu_pkg::*;
;

  // About 80 commands at roughly 20 cycles each, with margin
  localparam int TIMEOUT_CYCLES = 4000;

  logic        clk;
  logic        rst_n;
  logic [4:0]  awaddr;
  logic        awvalid;
  logic        awready;
  logic [31:0] wdata;
  logic        wvalid;
  logic        wready;
  logic [1:0]  bresp;
  logic        bvalid;
  logic        bready;
  logic [4:0]  araddr;
  logic        arvalid;
  logic        arready;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic        rvalid;
  logic        rready;

  logic        carry;          // Host copy of flag C
  int          expected_done;
  int          check_errors;
  int          test_errors_start;
  int          tests_passed;
  int          tests_failed;
  int          cycle_count;
  logic [31:0] last_rd;

  alu_accel_top u_dut (.*);

  `include "axil_host_tasks.svh"

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Result: FAILED");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp)
    else begin
      $display("ERROR t=%0t %s: expected 0x%0h, got 0x%0h", $time, name, exp, got);
      check_errors++;
    end
  endtask

  task automatic start_test();
    test_errors_start = check_errors;
  endtask

  task automatic end_test(input string name);
    if (check_errors == test_errors_start) begin
      tests_passed++;
      $display("Test %s: ok", name);
    end else begin
      tests_failed++;
      $display("Test %s: %0d checks failed", name, check_errors - test_errors_start);
    end
  endtask

  // Poll STATUS until the completion count reaches target
  task automatic wait_done(input int target);
    logic [31:0] d;
    logic [1:0]  resp;
    do begin
      axil_read(REG_STATUS, d, resp);
      check_value("rresp", resp, RESP_OKAY);
    end while (d[15:0] !== target[15:0]);
    check_value("status", d, 32'h0002_0000 | target[15:0]);   // Queue drained
  endtask

  task automatic run_cmd(input logic [4:0] op, input logic [15:0] x, input logic [15:0] y);
    logic [1:0]  resp;
    logic [23:0] exp;
    axil_write(REG_X, {16'h0000, x}, resp);
    check_value("bresp", resp, RESP_OKAY);
    axil_write(REG_Y, {16'h0000, y}, resp);
    check_value("bresp", resp, RESP_OKAY);
    axil_write(REG_OP, {27'h0, op}, resp);
    check_value("bresp", resp, RESP_OKAY);
    exp   = alu_model(op, x, y, carry);
    carry = exp[16 + FLAG_C];
    expected_done++;
    wait_done(expected_done);
    axil_read(REG_RESULT, last_rd, resp);
    check_value("rresp", resp, RESP_OKAY);
    check_value("result", last_rd[15:0], exp[15:0]);
    check_value("flags", last_rd[23:16], exp[23:16]);
    check_value("rdata[31:24]", last_rd[31:24], 8'h00);
  endtask

  initial begin
    logic [1:0]  resp;
    logic [31:0] d;
    logic [31:0] rx;
    logic [31:0] ry;
    logic [23:0] exp;
    int          op_i;
    int          k;
    clk = 1'b0;
    rst_n = 1'b0;
    awaddr = '0;
    awvalid = 1'b0;
    wdata = '0;
    wvalid = 1'b0;
    bready = 1'b0;
    araddr = '0;
    arvalid = 1'b0;
    rready = 1'b0;
    carry = 1'b0;
    expected_done = 0;
    check_errors = 0;
    tests_passed = 0;
    tests_failed = 0;
    cycle_count = 0;
    rx = $urandom(11);
    repeat (5) @(negedge clk);
    rst_n = 1'b1;

    start_test();
    axil_read(REG_RESULT, d, resp);
    check_value("rresp", resp, RESP_OKAY);
    check_value("rdata", d, 32'h0000_0000);
    axil_read(REG_STATUS, d, resp);
    check_value("rdata", d, 32'h0002_0000);   // Empty, not full, count 0
    axil_write(REG_X, 32'h0, resp);
    check_value("bresp", resp, RESP_OKAY);
    end_test("reset_state");

    start_test();
    run_cmd(OP_ADD8, 16'h0000, 16'h0000);
    run_cmd(OP_ADD8, 16'h007F, 16'h0001);   // Signed overflow
    run_cmd(OP_SUB8, 16'h0080, 16'h0001);
    run_cmd(OP_SUB8, 16'h0042, 16'h0042);
    run_cmd(OP_ADD16, 16'h7FFF, 16'h0001);
    run_cmd(OP_ADD16, 16'hFFFF, 16'h0001);
    run_cmd(OP_SUB16, 16'h8000, 16'h0001);
    run_cmd(OP_BIT, 16'h0010, 16'h0004);    // Bit set
    run_cmd(OP_BIT, 16'h0010, 16'h0005);
    run_cmd(OP_RES, 16'h00FF, 16'h0007);
    run_cmd(OP_SET, 16'h0000, 16'h0007);
    run_cmd(OP_AND, 16'h00F0, 16'h000F);
    for (op_i = 0; op_i <= 20; op_i++) begin
      for (k = 0; k < 2; k++) begin
        rx = $urandom;
        ry = $urandom;
        run_cmd(op_i[4:0], rx[15:0], ry[15:0]);
      end
    end
    end_test("every_opcode");

    start_test();
    run_cmd(OP_ADD8, 16'h00FF, 16'h0001);
    check_value("flags[C]", last_rd[16 + FLAG_C], 1'b1);
    run_cmd(OP_ADC, 16'h0010, 16'h0020);
    check_value("result", last_rd[15:0], 16'h0031);   // Carry added
    run_cmd(OP_ADD8, 16'h00FF, 16'h0001);
    run_cmd(OP_RL, 16'h0080, 16'h0000);
    check_value("result", last_rd[15:0], 16'h0001);
    run_cmd(OP_AND, 16'h000F, 16'h00F0);
    check_value("flags[C]", last_rd[16 + FLAG_C], 1'b0);
    run_cmd(OP_ADC, 16'h0010, 16'h0020);
    check_value("result", last_rd[15:0], 16'h0030);
    end_test("carry_chain");

    start_test();
    axil_write(REG_X, 32'h0000_0081, resp);
    check_value("bresp", resp, RESP_OKAY);
    axil_write(REG_Y, 32'h0000_0080, resp);
    check_value("bresp", resp, RESP_OKAY);
    // Six commands queued with no polling between them
    for (k = 0; k < 6; k++) begin
      case (k)
        0: op_i = OP_ADD8;
        1: op_i = OP_ADC;
        2: op_i = OP_RL;
        3: op_i = OP_SBC;
        4: op_i = OP_RR;
        default: op_i = OP_ADD16;
      endcase
      axil_write(REG_OP, op_i, resp);
      check_value("bresp", resp, RESP_OKAY);
      exp   = alu_model(op_i[4:0], 16'h0081, 16'h0080, carry);
      carry = exp[16 + FLAG_C];
      expected_done++;
    end
    wait_done(expected_done);
    axil_read(REG_RESULT, d, resp);
    check_value("result", d[15:0], exp[15:0]);
    check_value("flags", d[23:16], exp[23:16]);
    end_test("backpressure_order");

    start_test();
    run_cmd(5'd25, 16'h1234, 16'h5678);
    check_value("rdata", last_rd, 32'h0000_0000);
    axil_read(5'h14, d, resp);
    check_value("rresp", resp, RESP_SLVERR);
    axil_write(5'h14, 32'hDEAD_BEEF, resp);
    check_value("bresp", resp, RESP_SLVERR);
    end_test("undefined_and_unmapped");

    $display("Tests passed %0d, failed %0d, failed checks %0d",
             tests_passed, tests_failed, check_errors);
    if (check_errors == 0 && tests_failed == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== rtl/alu_accel_top.sv ====
`timescale 1ns/1ns

module alu_accel_top
  import alu_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic [ADDR_W-1:0] awaddr,
  input  logic              awvalid,
  output logic              awready,
  input  logic [AXI_DW-1:0] wdata,
  input  logic              wvalid,
  output logic              wready,
  output logic [1:0]        bresp,
  output logic              bvalid,
  input  logic              bready,
  input  logic [ADDR_W-1:0] araddr,
  input  logic              arvalid,
  output logic              arready,
  output logic [AXI_DW-1:0] rdata,
  output logic [1:0]        rresp,
  output logic              rvalid,
  input  logic              rready
);

  logic              push;
  logic [CMD_W-1:0]  push_data;
  logic              full;
  logic              empty;
  logic [CNT_W-1:0]  count;
  logic              pop;
  logic [CMD_W-1:0]  pop_data;
  logic [DATA_W-1:0] result;
  logic [7:0]        flags;
  logic [DATA_W-1:0] done_count;

  axil_cmd_port u_port (
    .clk        (clk),
    .rst_n      (rst_n),
    .awaddr     (awaddr),
    .awvalid    (awvalid),
    .awready    (awready),
    .wdata      (wdata),
    .wvalid     (wvalid),
    .wready     (wready),
    .bresp      (bresp),
    .bvalid     (bvalid),
    .bready     (bready),
    .araddr     (araddr),
    .arvalid    (arvalid),
    .arready    (arready),
    .rdata      (rdata),
    .rresp      (rresp),
    .rvalid     (rvalid),
    .rready     (rready),
    .full       (full),
    .count      (count),
    .result     (result),
    .flags      (flags),
    .done_count (done_count),
    .push       (push),
    .push_data  (push_data)
  );

  cmd_fifo u_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (push),
    .push_data (push_data),
    .pop       (pop),
    .pop_data  (pop_data),
    .full      (full),
    .empty     (empty),
    .count     (count)
  );

  alu_exec u_exec (
    .clk        (clk),
    .rst_n      (rst_n),
    .empty      (empty),
    .pop_data   (pop_data),
    .pop        (pop),
    .result     (result),
    .flags      (flags),
    .done_count (done_count)
  );

endmodule

// ==== rtl/alu_exec.sv ====
`timescale 1ns/1ns

module alu_exec
  import alu_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              empty,
  input  logic [CMD_W-1:0]  pop_data,
  output logic              pop,
  output logic [DATA_W-1:0] result,
  output logic [7:0]        flags,
  output logic [DATA_W-1:0] done_count
);

  alu_op_e           cmd_op;
  logic [DATA_W-1:0] cmd_x;
  logic [DATA_W-1:0] cmd_y;
  logic [DATA_W-1:0] alu_result;
  logic [7:0]        alu_flags;

  assign pop = !empty;   // Take a command every cycle one is waiting

  // Command layout is opcode, X, Y from the top
  assign cmd_op = alu_op_e'(pop_data[CMD_W-1 -: OP_W]);
  assign cmd_x  = pop_data[2*DATA_W-1 -: DATA_W];
  assign cmd_y  = pop_data[DATA_W-1:0];

  alu u_alu (
    .cin    (flags[FLAG_C]),
    .alu_op (cmd_op),
    .x      (cmd_x),
    .y      (cmd_y),
    .flags  (alu_flags),
    .result (alu_result)
  );

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      result     <= '0;
      flags      <= '0;
      done_count <= '0;
    end else if (pop) begin
      result     <= alu_result;
      flags      <= alu_flags;   // Carry chains into the next command
      done_count <= done_count + 1'b1;
    end
  end

endmodule

// ==== rtl/axil_cmd_port.sv ====
`timescale 1ns/1ns

module axil_cmd_port
  import alu_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic [ADDR_W-1:0] awaddr,
  input  logic              awvalid,
  output logic              awready,
  input  logic [AXI_DW-1:0] wdata,
  input  logic              wvalid,
  output logic              wready,
  output logic [1:0]        bresp,
  output logic              bvalid,
  input  logic              bready,
  input  logic [ADDR_W-1:0] araddr,
  input  logic              arvalid,
  output logic              arready,
  output logic [AXI_DW-1:0] rdata,
  output logic [1:0]        rresp,
  output logic              rvalid,
  input  logic              rready,
  input  logic              full,
  input  logic [CNT_W-1:0]  count,
  input  logic [DATA_W-1:0] result,
  input  logic [7:0]        flags,
  input  logic [DATA_W-1:0] done_count,
  output logic              push,
  output logic [CMD_W-1:0]  push_data
);

  logic [DATA_W-1:0] x_reg;
  logic [DATA_W-1:0] y_reg;
  logic              wr_is_op;
  logic              wr_start;
  logic              wr_accept;
  logic              rd_accept;
  logic              rvalid_next;

  function automatic logic addr_mapped(input logic [ADDR_W-1:0] addr);
    return (addr == REG_X) || (addr == REG_Y) || (addr == REG_OP) ||
           (addr == REG_RESULT) || (addr == REG_STATUS);
  endfunction

  assign wr_is_op = (awaddr == REG_OP);

  // Opcode write waits while the queue is full
  assign wr_start  = awvalid && wvalid && !awready && !bvalid && !(wr_is_op && full);
  assign wr_accept = awready && awvalid && wvalid;
  assign push      = wr_accept && wr_is_op;
  assign push_data = {wdata[OP_W-1:0], x_reg, y_reg};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      awready <= 1'b0;
      wready  <= 1'b0;
      bvalid  <= 1'b0;
    end else begin
      awready <= wr_start;   // One-cycle pulse
      wready  <= wr_start;
      if (wr_accept)
        bvalid <= 1'b1;
      else if (bready)
        bvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_accept)
      bresp <= addr_mapped(awaddr) ? RESP_OKAY : RESP_SLVERR;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      x_reg <= '0;
      y_reg <= '0;
    end else if (wr_accept) begin
      if (awaddr == REG_X)
        x_reg <= wdata[DATA_W-1:0];
      if (awaddr == REG_Y)
        y_reg <= wdata[DATA_W-1:0];
    end
  end

  assign rd_accept   = arready && arvalid;
  assign rvalid_next = rd_accept || (rvalid && !rready);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rvalid  <= 1'b0;
      arready <= 1'b0;
    end else begin
      rvalid  <= rvalid_next;
      arready <= !rvalid_next;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_accept) begin
      rresp <= addr_mapped(araddr) ? RESP_OKAY : RESP_SLVERR;
      case (araddr)
        REG_RESULT: rdata <= {8'b0, flags, result};
        REG_STATUS: rdata <= {14'b0, (count == '0), full, done_count};
        default:    rdata <= '0;   // Write-only and unmapped read zero
      endcase
    end
  end

endmodule

// ==== rtl/cmd_fifo.sv ====
`timescale 1ns/1ns

module cmd_fifo
  import alu_pkg::*;
(
  input  logic             clk,
  input  logic             rst_n,
  input  logic             push,
  input  logic [CMD_W-1:0] push_data,
  input  logic             pop,
  output logic [CMD_W-1:0] pop_data,
  output logic             full,
  output logic             empty,
  output logic [CNT_W-1:0] count
);

  logic [CMD_W-1:0] mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic             do_push;
  logic             do_pop;

  assign full     = (count == CNT_W'(FIFO_DEPTH));
  assign empty    = (count == '0);
  assign do_push  = push && !full;   // Dropped if the port missed full
  assign do_pop   = pop && !empty;
  assign pop_data = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push)
      mem[wr_ptr] <= push_data;
  end

  // Pointers wrap on their own, depth is a power of two
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
    end
  end

endmodule

// ==== rtl/alu.sv ====
`timescale 1ns/1ns

module alu
  import alu_pkg::*;
(
  input  logic              cin,
  input  alu_op_e           alu_op,
  input  logic [DATA_W-1:0] x,
  input  logic [DATA_W-1:0] y,
  output logic [7:0]        flags,
  output logic [DATA_W-1:0] result
);

  logic [8:0]  sum8;   // Bit 8 is carry or borrow
  logic [16:0] sum16;
  logic        cin_use;
  logic        wide;
  logic        op_valid;
  logic [7:0]  bit_mask;
  logic        c;
  logic        v;
  logic        s;
  logic        z;
  logic        n;

  assign cin_use  = cin & ((alu_op == OP_ADC) | (alu_op == OP_SBC));
  assign wide     = (alu_op == OP_ADD16) | (alu_op == OP_SUB16);
  assign op_valid = (alu_op <= OP_BIT);
  assign bit_mask = 8'h01 << y[2:0];   // RES and SET target

  // 8-bit arithmetic works on the low bytes only
  always_comb begin
    if (alu_op == OP_SUB8 || alu_op == OP_SBC)
      sum8 = {1'b0, x[7:0]} - {1'b0, y[7:0]} - {8'b0, cin_use};
    else
      sum8 = {1'b0, x[7:0]} + {1'b0, y[7:0]} + {8'b0, cin_use};
  end

  assign sum16 = (alu_op == OP_SUB16) ? ({1'b0, x} - {1'b0, y}) : ({1'b0, x} + {1'b0, y});

  always_comb begin
    result = '0;
    c      = 1'b0;
    v      = 1'b0;
    case (alu_op)
      OP_ADD8, OP_ADC: begin
        result[7:0] = sum8[7:0];
        c           = sum8[8];
        v           = (x[7] == y[7]) && (sum8[7] != x[7]);
      end
      OP_SUB8, OP_SBC: begin
        result[7:0] = sum8[7:0];
        c           = sum8[8];
        v           = (x[7] != y[7]) && (sum8[7] != x[7]);
      end
      OP_AND: result[7:0] = x[7:0] & y[7:0];
      OP_OR:  result[7:0] = x[7:0] | y[7:0];
      OP_XOR: result[7:0] = x[7:0] ^ y[7:0];
      OP_NOT: result[7:0] = ~x[7:0];
      OP_ADD16: begin
        result = sum16[15:0];
        c      = sum16[16];
        v      = (x[15] == y[15]) && (sum16[15] != x[15]);
      end
      OP_SUB16: begin
        result = sum16[15:0];
        c      = sum16[16];
        v      = (x[15] != y[15]) && (sum16[15] != x[15]);
      end
      OP_RR: begin
        result[7:0] = {cin, x[7:1]};   // Through carry
        c           = x[0];
      end
      OP_RL: begin
        result[7:0] = {x[6:0], cin};
        c           = x[7];
      end
      OP_RRC: begin
        result[7:0] = {x[0], x[7:1]};
        c           = x[0];
      end
      OP_RLC: begin
        result[7:0] = {x[6:0], x[7]};
        c           = x[7];
      end
      OP_SLA: begin
        result[7:0] = {x[6:0], 1'b0};
        c           = x[7];
      end
      OP_SRA: begin
        result[7:0] = {x[7], x[7:1]};   // Sign kept
        c           = x[0];
      end
      OP_SLL: begin
        result[7:0] = {x[6:0], 1'b1};
        c           = x[7];
      end
      OP_SRL: begin
        result[7:0] = {1'b0, x[7:1]};
        c           = x[0];
      end
      OP_RES: result[7:0] = x[7:0] & ~bit_mask;
      OP_SET: result[7:0] = x[7:0] | bit_mask;
      default: ;   // BIT and undefined codes give zero
    endcase

    // Even parity replaces overflow here
    case (alu_op)
      OP_AND, OP_OR, OP_XOR, OP_SLA, OP_SRA, OP_SLL: v = ~^result[7:0];
      default: ;
    endcase
  end

  assign s = wide ? result[15] : result[7];
  assign z = (alu_op == OP_BIT) ? ~x[y[3:0]] : (result == '0);
  assign n = (alu_op == OP_ADD8) | (alu_op == OP_ADC) | (alu_op == OP_ADD16);

  always_comb begin
    flags = '0;
    if (op_valid) begin
      flags[FLAG_C] = c;
      flags[FLAG_N] = n;
      flags[FLAG_V] = v;
      flags[FLAG_Z] = z;
      flags[FLAG_S] = s;
    end
  end

endmodule

// ==== rtl/alu_pkg.sv ====
package alu_pkg;

  // Datapath sizes
  localparam int DATA_W     = 16;
  localparam int OP_W       = 5;
  localparam int CMD_W      = OP_W + 2 * DATA_W;   // Opcode, X, Y
  localparam int FIFO_DEPTH = 4;
  localparam int PTR_W      = $clog2(FIFO_DEPTH);
  localparam int CNT_W      = PTR_W + 1;

  // AXI4-Lite port sizes
  localparam int ADDR_W = 5;
  localparam int AXI_DW = 32;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // Flag byte layout, bits 3 to 5 stay zero
  localparam int FLAG_C = 0;
  localparam int FLAG_N = 1;
  localparam int FLAG_V = 2;   // Parity or overflow
  localparam int FLAG_Z = 6;
  localparam int FLAG_S = 7;

  // Register map
  localparam logic [ADDR_W-1:0] REG_X      = 5'h00;
  localparam logic [ADDR_W-1:0] REG_Y      = 5'h04;
  localparam logic [ADDR_W-1:0] REG_OP     = 5'h08;
  localparam logic [ADDR_W-1:0] REG_RESULT = 5'h0C;
  localparam logic [ADDR_W-1:0] REG_STATUS = 5'h10;

  typedef enum logic [OP_W-1:0] {
    OP_ADD8 = 5'd0,
    OP_SUB8,
    OP_ADC,
    OP_SBC,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_NOT,
    OP_ADD16,
    OP_SUB16,
    OP_RR,
    OP_RL,
    OP_RRC,
    OP_RLC,
    OP_SLA,
    OP_SRA,
    OP_SLL,
    OP_SRL,
    OP_RES,
    OP_SET,
    OP_BIT    // 20, codes above are undefined
  } alu_op_e;

endpackage
